// ==== bench/rv_cases.txt ====
// @000 header: interrupt request cycle, number of expected stores
// @010 expected stores, one per line: bus_address bus_write_data
@000
0000000000000016
0000000000000007
@010
ffffffff80001000 0000000000000123
ffffffff80001008 0000000000000122
ffffffff80001010 0000000000000123
ffffffff80001020 0000000080000020
ffffffff80001030 0000000000000000
ffffffff80001040 00000000000007ab
ffffffff80001038 0000000000000077
// @100 main program, one instruction per word offset from RAM_BASE
@100
800010b7 // lui  x1, 0x80001
12300113 // addi x2, x0, 0x123
fff10193 // addi x3, x2, -1
0020b023 // sd   x2, 0(x1)
0030b423 // sd   x3, 8(x1)
0000b203 // ld   x4, 0(x1)
0040b823 // sd   x4, 16(x1)
008002ef // jal  x5, +8
0020bc23 // sd   x2, 24(x1), skipped
0250b023 // sd   x5, 32(x1)
0080006f // jal  x0, +8
0230b423 // sd   x3, 40(x1), skipped
0200b823 // sd   x0, 48(x1)
05500313 // addi x6, x0, 0x55
01130313 // addi x6, x6, 0x11
01130313 // addi x6, x6, 0x11
0260bc23 // sd   x6, 56(x1)
0000006f // jal  x0, 0
// @140 interrupt handler at TRAP_BASE
@140
80001537 // lui  x10, 0x80001
7ab00593 // addi x11, x0, 0x7ab
04b53023 // sd   x11, 64(x10)
30200073 // mret

// ==== bench/tb_rv_soc.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_rv_soc;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 10;
    localparam int CASES_DEPTH  = 512;
    localparam int STORE_BASE   = 'h010;   // Expected (address, data) pairs
    localparam int PROG_BASE    = 'h100;   // Program words, index = word offset from RAM_BASE
    localparam int PROG_WORDS   = 256;

    logic                         clk;
    logic                         reset;
    logic [rv_pkg::ILEN-1:0]      instruction;
    logic [3:0]                   interrupt_vector;
    logic [rv_pkg::XLEN-1:0]      pc;
    logic                         heartbeat;
    logic                         interrupt_ack;
    logic                         bus_write_enable;
    logic [rv_pkg::XLEN-1:0]      bus_address;
    logic [rv_pkg::XLEN-1:0]      bus_write_data;

    logic [63:0]                  cases_mem [CASES_DEPTH];

    int                           irq_cycle;      // First cycle of the interrupt request
    int                           store_count;
    int                           program_words;
    int                           timeout_limit;
    int                           cycle;          // Cycles since reset release
    int                           stores_seen;
    int                           ack_count;
    logic                         irq_done;       // First interrupt_ack already seen
    logic                         prev_heartbeat;
    logic                         hb_valid;
    logic [63:0]                  exp_addr;
    logic [63:0]                  exp_data;

    rv_soc rv_soc_inst (
        .clk              (clk),
        .reset            (reset),
        .instruction      (instruction),
        .interrupt_vector (interrupt_vector),
        .pc               (pc),
        .heartbeat        (heartbeat),
        .interrupt_ack    (interrupt_ack),
        .bus_write_enable (bus_write_enable),
        .bus_address      (bus_address),
        .bus_write_data   (bus_write_data)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic stop_with_failure();
        $display("Simulation failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_mismatch(input string what, input logic [63:0] got,
                                   input logic [63:0] expected);
        $display("CHECK FAILED at %0d ns: %s is %h, expected %h", $time, what, got, expected);
        stop_with_failure();
    endtask

    // Instruction supply, NOP outside the loaded program
    function automatic logic [rv_pkg::ILEN-1:0] fetch_word(input logic [rv_pkg::XLEN-1:0] addr);
        logic [rv_pkg::XLEN-1:0] offset;
        logic [63:0]             word;
        offset = addr - rv_pkg::RAM_BASE;
        if (offset >= 64'(4 * PROG_WORDS) || offset[1:0] != 2'b00) begin
            return rv_pkg::NOP_INSN;
        end
        word = cases_mem[PROG_BASE + int'(offset[9:2])];
        if ($isunknown(word) || word == 64'd0) begin
            return rv_pkg::NOP_INSN; // Empty slot
        end
        return word[rv_pkg::ILEN-1:0];
    endfunction

    function automatic int count_program_words();
        int n;
        n = 0;
        for (int i = 0; i < PROG_WORDS; i++) begin
            if (!$isunknown(cases_mem[PROG_BASE + i]) && cases_mem[PROG_BASE + i] != 64'd0) begin
                n++;
            end
        end
        return n;
    endfunction

    // First request held until acknowledged, second one raised inside the handler
    function automatic logic [3:0] irq_request();
        if (!irq_done && cycle >= irq_cycle) begin
            return rv_pkg::IRQ_EXTERNAL;
        end
        if (irq_done && pc >= rv_pkg::TRAP_BASE) begin
            return rv_pkg::IRQ_EXTERNAL; // MIE clear here, must be ignored
        end
        return 4'd0;
    endfunction

    task automatic finish_run();
        if (ack_count == 1) begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            report_mismatch("interrupt_ack pulse count", 64'(ack_count), 64'd1);
        end
    endtask

    // Reset, then drive inputs 1 ns after every rising edge
    initial begin
        reset            = 1'b0;
        instruction      = rv_pkg::NOP_INSN;
        interrupt_vector = 4'd0;
        cycle            = 0;
        stores_seen      = 0;
        ack_count        = 0;
        irq_done         = 1'b0;
        hb_valid         = 1'b0;
        prev_heartbeat   = 1'b0;
        $readmemh("bench/rv_cases.txt", cases_mem);
        irq_cycle     = int'(cases_mem[0]);
        store_count   = int'(cases_mem[1]);
        program_words = count_program_words();
        timeout_limit = 4 * program_words + 100;
        assert (store_count > 0 && program_words > 0) else begin
            $display("Cases file holds no program or no expected stores");
            stop_with_failure();
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset            = 1'b1;
        instruction      = fetch_word(pc);
        interrupt_vector = irq_request();
        forever begin
            @(posedge clk);
            #1;
            cycle = cycle + 1;
            if (interrupt_ack) irq_done = 1'b1; // Drop the first request
            instruction      = fetch_word(pc);
            interrupt_vector = irq_request();
        end
    end

    // Outputs sampled mid-cycle where they are stable
    always @(negedge clk) begin
        if (reset === 1'b1) begin
            assert (cycle < timeout_limit) else begin
                $display("Timeout after %0d cycles, only %0d of %0d expected stores appeared",
                         cycle, stores_seen, store_count);
                stop_with_failure();
            end

            if (hb_valid) begin
                assert (heartbeat != prev_heartbeat)
                    else report_mismatch("heartbeat", 64'(heartbeat), 64'(~prev_heartbeat));
            end
            prev_heartbeat = heartbeat;
            hb_valid       = 1'b1;

            if (interrupt_ack) begin
                ack_count++;
                assert (pc == rv_pkg::TRAP_BASE)
                    else report_mismatch("pc at interrupt_ack", pc, rv_pkg::TRAP_BASE);
                assert (ack_count == 1) else begin
                    $display("Interrupt acknowledged again at %0d ns although MIE was clear",
                             $time);
                    stop_with_failure();
                end
            end

            if (bus_write_enable) begin
                exp_addr = cases_mem[STORE_BASE + 2 * stores_seen];
                exp_data = cases_mem[STORE_BASE + 2 * stores_seen + 1];
                assert (bus_address == exp_addr)
                    else report_mismatch("store address", bus_address, exp_addr);
                assert (bus_write_data == exp_data)
                    else report_mismatch("store data", bus_write_data, exp_data);
                stores_seen++;
                if (stores_seen == store_count) finish_run();
            end
        end
    end

endmodule

`default_nettype wire

// ==== project.f ====
src/rv_pkg.sv
src/rv_regfile.sv
src/rv_decode.sv
src/rv_csr_unit.sv
src/rv_core.sv
src/rv_data_ram.sv
src/rv_soc.sv
bench/tb_rv_soc.sv

// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator and run it from the project root
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
    --top-module tb_rv_soc \
    -o sim_tb_rv_soc \
    -f project.f

# The simulator exits non-zero on a failed check, the log decides the result
./obj_dir/sim_tb_rv_soc > sim.log 2>&1 || true
cat sim.log

if grep -qx "Simulation completed successfully" sim.log; then
    echo "run.sh: PASS"
else
    echo "run.sh: FAIL, see sim.log"
    exit 1
fi

// ==== src/rv_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_core (
    input  logic                     clk,
    input  logic                     reset,
    input  logic [rv_pkg::ILEN-1:0]  instruction,      // Word at current pc
    input  logic [3:0]               interrupt_vector,
    output logic [rv_pkg::XLEN-1:0]  pc,
    output logic                     heartbeat,
    output logic                     interrupt_ack,
    output logic [rv_pkg::XLEN-1:0]  bus_address,
    output logic [rv_pkg::XLEN-1:0]  bus_write_data,
    output logic                     bus_write_enable,
    output logic                     bus_read_enable,
    input  logic [rv_pkg::XLEN-1:0]  bus_read_data
);

    logic [rv_pkg::ILEN-1:0]       ir;       // Fetch register
    logic                          bubble;   // Squash the word in ir
    logic                          ld_step;  // 0 issue read, 1 write back

    rv_pkg::op_kind_e              kind;
    logic [rv_pkg::REG_ADDR_W-1:0] rd;
    logic [rv_pkg::REG_ADDR_W-1:0] rs1;
    logic [rv_pkg::REG_ADDR_W-1:0] rs2;
    logic [rv_pkg::XLEN-1:0]       imm_u;
    logic [rv_pkg::XLEN-1:0]       imm_i;
    logic [rv_pkg::XLEN-1:0]       imm_s;
    logic [rv_pkg::XLEN-1:0]       imm_j;
    logic [rv_pkg::XLEN-1:0]       rs1_data;
    logic [rv_pkg::XLEN-1:0]       rs2_data;

    logic                          rd_we;
    logic [rv_pkg::XLEN-1:0]       rd_data;

    logic                          trap_take;
    logic                          mret_take;
    logic [rv_pkg::XLEN-1:0]       trap_pc;
    logic                          mie_bit;
    logic [rv_pkg::XLEN-1:0]       mepc;

    logic                          executing;
    logic [rv_pkg::XLEN-1:0]       ex_pc;    // Address of the word in ir

    rv_decode rv_decode_inst (
        .ir    (ir),
        .kind  (kind),
        .rd    (rd),
        .rs1   (rs1),
        .rs2   (rs2),
        .imm_u (imm_u),
        .imm_i (imm_i),
        .imm_s (imm_s),
        .imm_j (imm_j)
    );

    rv_regfile rv_regfile_inst (
        .clk      (clk),
        .reset    (reset),
        .rs1_addr (rs1),
        .rs2_addr (rs2),
        .rd_addr  (rd),
        .rd_we    (rd_we),
        .rd_data  (rd_data),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    rv_csr_unit rv_csr_unit_inst (
        .clk       (clk),
        .reset     (reset),
        .trap_take (trap_take),
        .trap_pc   (trap_pc),
        .mret_take (mret_take),
        .mie_bit   (mie_bit),
        .mepc      (mepc)
    );

    // pc already runs one word ahead of ir
    assign ex_pc = pc - 64'd4;

    // Interrupt wins over everything, including a pending bubble
    assign trap_take = (interrupt_vector == rv_pkg::IRQ_EXTERNAL) && mie_bit;
    assign executing = !trap_take && !bubble;
    assign mret_take = executing && (kind == rv_pkg::OPK_MRET);

    // Squashed ir: pc already holds the resume point; live ir: resume at ir itself
    assign trap_pc = bubble ? pc : ex_pc;

    // Register write port
    always_comb begin
        rd_we   = 1'b0;
        rd_data = '0;
        if (executing) begin
            case (kind)
                rv_pkg::OPK_LUI: begin
                    rd_we   = 1'b1;
                    rd_data = imm_u;
                end
                rv_pkg::OPK_ADDI: begin
                    rd_we   = 1'b1;
                    rd_data = rs1_data + imm_i;
                end
                rv_pkg::OPK_JAL: begin
                    rd_we   = 1'b1;
                    rd_data = pc; // Link, jal address + 4
                end
                rv_pkg::OPK_LD: begin
                    rd_we   = ld_step;       // Only on second pass
                    rd_data = bus_read_data;
                end
                default: rd_we = 1'b0;
            endcase
        end
    end

    // Fetch, pc sequencing and control flags
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            heartbeat        <= 1'b0;
            ir               <= rv_pkg::NOP_INSN;
            pc               <= rv_pkg::RAM_BASE;
            bubble           <= 1'b0;
            ld_step          <= 1'b0;
            interrupt_ack    <= 1'b0;
            bus_write_enable <= 1'b0;
            bus_read_enable  <= 1'b0;
        end else begin
            heartbeat        <= ~heartbeat;
            ir               <= instruction;
            pc               <= pc + 64'd4; // Default, overridden below
            interrupt_ack    <= 1'b0;
            bus_write_enable <= 1'b0;
            bus_read_enable  <= 1'b0;
            if (trap_take) begin
                pc            <= rv_pkg::TRAP_BASE;
                bubble        <= 1'b1;     // Drop word fetched at old pc
                ld_step       <= 1'b0;     // Interrupted ld restarts from step 0
                interrupt_ack <= 1'b1;
            end else if (bubble) begin
                bubble <= 1'b0;            // Flush one cycle
            end else begin
                case (kind)
                    rv_pkg::OPK_JAL: begin
                        pc     <= ex_pc + imm_j;
                        bubble <= 1'b1;
                    end
                    rv_pkg::OPK_SD: begin
                        pc               <= pc; // Re-fetch the next word after the bubble
                        bubble           <= 1'b1;
                        bus_write_enable <= 1'b1;
                    end
                    rv_pkg::OPK_LD: begin
                        if (!ld_step) begin
                            pc              <= ex_pc; // Rewind onto the ld itself
                            bubble          <= 1'b1;  // RAM reads during the bubble
                            ld_step         <= 1'b1;
                            bus_read_enable <= 1'b1;
                        end else begin
                            ld_step <= 1'b0;
                        end
                    end
                    rv_pkg::OPK_MRET: begin
                        pc     <= mepc;
                        bubble <= 1'b1;
                    end
                    default: ; // lui, addi and unknown words need no pc change
                endcase
            end
        end
    end

    // Bus address and store data, qualified by the strobes
    always_ff @(posedge clk) begin
        if (executing && kind == rv_pkg::OPK_SD) begin
            bus_address    <= rs1_data + imm_s;
            bus_write_data <= rs2_data;
        end else if (executing && kind == rv_pkg::OPK_LD && !ld_step) begin
            bus_address <= rs1_data + imm_i;
        end
    end

endmodule

`default_nettype wire

// ==== src/rv_csr_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_csr_unit (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     trap_take,  // Pulse, interrupt accepted
    input  logic [rv_pkg::XLEN-1:0]  trap_pc,    // Resume address
    input  logic                     mret_take,  // Pulse, mret retiring
    output logic                     mie_bit,
    output logic [rv_pkg::XLEN-1:0]  mepc
);

    logic [rv_pkg::XLEN-1:0] mstatus;

    // Global interrupt enable straight from mstatus
    assign mie_bit = mstatus[rv_pkg::MSTATUS_MIE];

    // mstatus interrupt stack, one level deep
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            mstatus                       <= '0;
            mstatus[rv_pkg::MSTATUS_MIE]  <= 1'b1; // Interrupts on out of reset
        end else if (trap_take) begin
            mstatus[rv_pkg::MSTATUS_MPIE] <= mstatus[rv_pkg::MSTATUS_MIE]; // Push
            mstatus[rv_pkg::MSTATUS_MIE]  <= 1'b0;                         // No nesting
        end else if (mret_take) begin
            mstatus[rv_pkg::MSTATUS_MIE]  <= mstatus[rv_pkg::MSTATUS_MPIE]; // Pop
            mstatus[rv_pkg::MSTATUS_MPIE] <= 1'b1;
        end
    end

    // Return address
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            mepc <= '0;
        end else if (trap_take) begin
            mepc <= trap_pc;
        end
    end

endmodule

`default_nettype wire

// ==== src/rv_data_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_data_ram (
    input  logic                     clk,
    input  logic [rv_pkg::XLEN-1:0]  address,       // Byte address on the bus
    input  logic [rv_pkg::XLEN-1:0]  write_data,
    input  logic                     write_enable,
    input  logic                     read_enable,
    output logic [rv_pkg::XLEN-1:0]  read_data      // Valid the cycle after read_enable
);

    logic [rv_pkg::XLEN-1:0]       mem [rv_pkg::RAM_WORDS];
    logic [rv_pkg::XLEN-1:0]       offset;
    logic [rv_pkg::RAM_ADDR_W-1:0] word_index;

    // Byte offset from the RAM base, then drop the 3 byte-select bits
    assign offset     = address - rv_pkg::RAM_BASE;
    assign word_index = offset[rv_pkg::RAM_ADDR_W+2:3];

    // Write on the strobe edge
    always_ff @(posedge clk) begin
        if (write_enable) begin
            mem[word_index] <= write_data;
        end
    end

    // Registered read, holds value between strobes
    always_ff @(posedge clk) begin
        if (read_enable) begin
            read_data <= mem[word_index];
        end
    end

endmodule

`default_nettype wire

// ==== src/rv_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_decode (
    input  logic [rv_pkg::ILEN-1:0]        ir,
    output rv_pkg::op_kind_e               kind,
    output logic [rv_pkg::REG_ADDR_W-1:0]  rd,
    output logic [rv_pkg::REG_ADDR_W-1:0]  rs1,
    output logic [rv_pkg::REG_ADDR_W-1:0]  rs2,
    output logic [rv_pkg::XLEN-1:0]        imm_u,
    output logic [rv_pkg::XLEN-1:0]        imm_i,
    output logic [rv_pkg::XLEN-1:0]        imm_s,
    output logic [rv_pkg::XLEN-1:0]        imm_j
);

    logic [6:0] opcode;
    logic [2:0] funct3;

    assign opcode = ir[6:0];
    assign funct3 = ir[14:12];

    // Register fields sit at fixed positions
    assign rd  = ir[11:7];
    assign rs1 = ir[19:15];
    assign rs2 = ir[24:20];

    // Sign-extended immediates
    assign imm_u = {{32{ir[31]}}, ir[31:12], 12'b0};                     // lui
    assign imm_i = {{52{ir[31]}}, ir[31:20]};                            // addi, ld
    assign imm_s = {{52{ir[31]}}, ir[31:25], ir[11:7]};                  // sd
    assign imm_j = {{44{ir[31]}}, ir[19:12], ir[20], ir[30:21], 1'b0};   // jal, bit 0 always 0

    // Operation class
    always_comb begin
        kind = rv_pkg::OPK_NONE; // Anything outside the subset
        case (opcode)
            rv_pkg::OP_LUI:   kind = rv_pkg::OPK_LUI;
            rv_pkg::OP_JAL:   kind = rv_pkg::OPK_JAL;
            rv_pkg::OP_OPIMM: begin
                if (funct3 == rv_pkg::F3_ADD) kind = rv_pkg::OPK_ADDI;
            end
            rv_pkg::OP_LOAD: begin
                if (funct3 == rv_pkg::F3_DOUBLE) kind = rv_pkg::OPK_LD;
            end
            rv_pkg::OP_STORE: begin
                if (funct3 == rv_pkg::F3_DOUBLE) kind = rv_pkg::OPK_SD;
            end
            rv_pkg::OP_SYSTEM: begin
                if (ir == rv_pkg::MRET_INSN) kind = rv_pkg::OPK_MRET; // Exact match only
            end
            default: kind = rv_pkg::OPK_NONE;
        endcase
    end

endmodule

`default_nettype wire

// ==== src/rv_pkg.sv ====
`default_nettype none

package rv_pkg;

    // Machine widths
    localparam int XLEN       = 64;
    localparam int ILEN       = 32;
    localparam int REG_COUNT  = 32;
    localparam int REG_ADDR_W = 5;

    // Memory map
    localparam logic [XLEN-1:0] RAM_BASE  = 64'h0000_0000_8000_0000; // Reset pc as well
    localparam int              RAM_WORDS = 256;                      // 64-bit words
    localparam int              RAM_ADDR_W = $clog2(RAM_WORDS);
    localparam logic [XLEN-1:0] TRAP_BASE = 64'h0000_0000_8000_0100; // Fixed handler, no mtvec

    localparam logic [ILEN-1:0] NOP_INSN = 32'h0000_0013; // addi x0,x0,0

    // Interrupt and CSR encodings
    localparam logic [3:0]      IRQ_EXTERNAL = 4'd1;
    localparam logic [XLEN-1:0] MCAUSE_MEI   = 64'h8000_0000_0000_000B; // Interrupt, code 11
    localparam int              MSTATUS_MIE  = 3;
    localparam int              MSTATUS_MPIE = 7;

    // Major opcodes
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_OPIMM  = 7'b0010011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_SYSTEM = 7'b1110011;

    localparam logic [2:0] F3_DOUBLE = 3'b011; // ld / sd
    localparam logic [2:0] F3_ADD    = 3'b000; // addi

    localparam logic [ILEN-1:0] MRET_INSN = 32'h3020_0073;

    // Operation class handed from decoder to core
    typedef enum logic [2:0] {
        OPK_NONE,
        OPK_LUI,
        OPK_ADDI,
        OPK_JAL,
        OPK_LD,
        OPK_SD,
        OPK_MRET
    } op_kind_e;

endpackage

`default_nettype wire

// ==== src/rv_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_regfile (
    input  logic                           clk,
    input  logic                           reset,
    input  logic [rv_pkg::REG_ADDR_W-1:0]  rs1_addr,
    input  logic [rv_pkg::REG_ADDR_W-1:0]  rs2_addr,
    input  logic [rv_pkg::REG_ADDR_W-1:0]  rd_addr,
    input  logic                           rd_we,
    input  logic [rv_pkg::XLEN-1:0]        rd_data,
    output logic [rv_pkg::XLEN-1:0]        rs1_data,
    output logic [rv_pkg::XLEN-1:0]        rs2_data
);

    logic [rv_pkg::XLEN-1:0] regs [rv_pkg::REG_COUNT];

    // Single write port, x0 never written
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < rv_pkg::REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (rd_we && rd_addr != '0) begin
            regs[rd_addr] <= rd_data;
        end
    end

    // Combinational reads
    always_comb begin
        rs1_data = regs[rs1_addr]; // x0 entry stays zero from reset
        rs2_data = regs[rs2_addr];
    end

endmodule

`default_nettype wire

// ==== src/rv_soc.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_soc (
    input  logic                     clk,
    input  logic                     reset,
    input  logic [rv_pkg::ILEN-1:0]  instruction,
    input  logic [3:0]               interrupt_vector,
    output logic [rv_pkg::XLEN-1:0]  pc,
    output logic                     heartbeat,
    output logic                     interrupt_ack,
    output logic                     bus_write_enable,
    output logic [rv_pkg::XLEN-1:0]  bus_address,
    output logic [rv_pkg::XLEN-1:0]  bus_write_data
);

    // Read side stays inside the SoC
    logic                    bus_read_enable;
    logic [rv_pkg::XLEN-1:0] bus_read_data;

    rv_core rv_core_inst (
        .clk              (clk),
        .reset            (reset),
        .instruction      (instruction),
        .interrupt_vector (interrupt_vector),
        .pc               (pc),
        .heartbeat        (heartbeat),
        .interrupt_ack    (interrupt_ack),
        .bus_address      (bus_address),
        .bus_write_data   (bus_write_data),
        .bus_write_enable (bus_write_enable),
        .bus_read_enable  (bus_read_enable),
        .bus_read_data    (bus_read_data)
    );

    // Data RAM, one-cycle answer, no stall path
    rv_data_ram rv_data_ram_inst (
        .clk          (clk),
        .address      (bus_address),
        .write_data   (bus_write_data),
        .write_enable (bus_write_enable),
        .read_enable  (bus_read_enable),
        .read_data    (bus_read_data)
    );

endmodule

`default_nettype wire
